//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Datapath and interrupt sizing
    localparam int dataWidth = 8;
    localparam int irqCount = 3;

    // Reset values of the program counter and the working registers
    localparam logic [dataWidth-1:0] resetPc = '0;
    localparam logic [dataWidth-1:0] resetReg = '0;

    // Data bus parks here whenever no access is running
    localparam logic [dataWidth-1:0] idleBusAddr = 8'hFF;

    // Thread start vectors, entry 0 belongs to line 0
    localparam logic [irqCount-1:0][dataWidth-1:0] irqVector = {8'hFD, 8'hFE, 8'hFF};

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding

    // Low nibble of every instruction byte
    typedef enum logic [3:0] {
        opLoadA  = 4'h0,
        opLoadB  = 4'h1,
        opStoreA = 4'h2,
        opStoreB = 4'h3,
        opMathA  = 4'h4,
        opMathB  = 4'h5,
        opBranch = 4'h6,
        opGoto   = 4'h7,
        opIdle   = 4'h8
    } opClass;

    // High nibble of a maths instruction
    typedef enum logic [3:0] {
        aluAdd         = 4'h0,
        aluSub         = 4'h1,
        aluAnd         = 4'h2,
        aluOr          = 4'h3,
        aluXor         = 4'h4,
        aluShiftLeftA  = 4'h5,
        aluShiftRightA = 4'h6,
        aluIncrementA  = 4'h7
    } aluOp;

    // High nibble of a branch, unsigned compare of A against B
    typedef enum logic [3:0] {
        condEqual       = 4'h0,
        condLessThan    = 4'h1,
        condGreaterThan = 4'h2,
        condNotEqual    = 4'h3
    } branchCond;

    typedef struct packed {
        aluOp   op;
        opClass cls;
    } mathFields;

    typedef struct packed {
        branchCond cond;
        opClass    cls;
    } branchFields;

    // Same byte, high nibble read as ALU op or as branch condition
    typedef union packed {
        mathFields   mathView;
        branchFields branchView;
    } instrWord;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer states, one chain per instruction class
    typedef enum logic [3:0] {
        seqChoose,
        seqLoadWait,
        seqLoadIssue,
        seqLoadStep,
        seqLoadTake,
        seqStoreStep,
        seqStoreIssue,
        seqMath,
        seqMathSettle,
        seqBranch,
        seqGotoWait,
        seqJumpLoad,
        seqJumpSettle,
        seqIdle,
        seqVectorWait,
        seqVectorLoad
    } seqState;

endpackage

`default_nettype wire

//--- rtl/cpuLinks.sv
`timescale 1ns/1ps
`default_nettype none

// Program counter commands
interface fetchLink import cpuPkg::*; ();
    logic                 operandSelect;
    logic                 stepOne;
    logic                 stepTwo;
    logic                 loadTarget;
    logic [dataWidth-1:0] targetAddr;

    modport driver (output operandSelect, stepOne, stepTwo, loadTarget, targetAddr);
    modport receiver (input operandSelect, stepOne, stepTwo, loadTarget, targetAddr);
endinterface

// Register writes and the branch result
interface execLink import cpuPkg::*; ();
    logic                 loadA;
    logic                 loadB;
    logic                 takeAlu;
    instrWord             instr;
    logic [dataWidth-1:0] memData;
    logic                 condTrue;

    modport driver (output loadA, loadB, takeAlu, instr, memData, input condTrue);
    modport receiver (input loadA, loadB, takeAlu, instr, memData, output condTrue);
endinterface

// Data memory access requests
interface busLink import cpuPkg::*; ();
    logic                 startRead;
    logic                 startWrite;
    logic                 writeFromB;
    logic [dataWidth-1:0] accessAddr;

    modport driver (output startRead, startWrite, writeFromB, accessAddr);
    modport receiver (input startRead, startWrite, writeFromB, accessAddr);
endinterface

`default_nettype wire

//--- rtl/interruptArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module interruptArbiter import cpuPkg::*; (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic [irqCount-1:0]  IrqRaise,
    input  logic                 inIdle,
    output logic [irqCount-1:0]  IrqAck,
    output logic                 wake,
    output logic [dataWidth-1:0] vectorAddr
);

    logic [irqCount-1:0] grant;

    // Lowest raised index wins, so scan from the top down
    always_comb begin
        grant = '0;
        vectorAddr = '0;
        for (int i = irqCount - 1; i >= 0; i--) begin
            if (IrqRaise[i]) begin
                grant = '0;
                grant[i] = 1'b1;
                vectorAddr = irqVector[i];
            end
        end
    end

    // Raises are only seen while the sequencer sits in idle
    assign wake = inIdle && (|IrqRaise);

    // One-cycle ack, idle is left on the same edge
    always_ff @(posedge CLK) begin
        if (RESET) begin
            IrqAck <= '0;
        end else begin
            IrqAck <= wake ? grant : '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import cpuPkg::*; (
    input  logic                 CLK,
    input  logic                 RESET,
    fetchLink.receiver           fetch,
    output logic [dataWidth-1:0] RomAddr
);

    logic [dataWidth-1:0] progCounter;
    logic                 operandOffset;

    ////////////////////////////////////////////////////////////////////////////
    // Program counter and operand offset

    always_ff @(posedge CLK) begin
        if (RESET) begin
            progCounter <= resetPc;
            operandOffset <= 1'b0;
        end else begin
            // Offset points at the operand byte for one cycle only
            operandOffset <= fetch.operandSelect;
            if (fetch.loadTarget) begin
                progCounter <= fetch.targetAddr;
            end else if (fetch.stepTwo) begin
                // Past opcode and operand
                progCounter <= progCounter + dataWidth'(2);
            end else if (fetch.stepOne) begin
                // Single-byte instruction
                progCounter <= progCounter + dataWidth'(1);
            end
        end
    end

    // ROM is registered, the byte shows up one cycle later
    assign RomAddr = progCounter + {{(dataWidth - 1){1'b0}}, operandOffset};

endmodule

`default_nettype wire

//--- rtl/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer import cpuPkg::*; (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic [dataWidth-1:0] RomData,
    input  logic [dataWidth-1:0] BusDataIn,
    input  logic                 wake,
    input  logic [dataWidth-1:0] vectorAddr,
    fetchLink.driver             fetch,
    execLink.driver              exec,
    busLink.driver               bus,
    output logic                 inIdle
);

    seqState  state;
    seqState  nextState;
    logic     selectB;
    logic     nextSelectB;
    instrWord romWord;

    assign romWord = RomData;

    // Opcode byte is still on the ROM output in the maths and branch states
    assign exec.instr = romWord;
    assign exec.memData = BusDataIn;

    assign inIdle = (state == seqIdle);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= seqChoose;
            selectB <= 1'b0;
        end else begin
            state <= nextState;
            selectB <= nextSelectB;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state and unit commands

    always_comb begin
        nextState = state;
        nextSelectB = selectB;
        fetch.operandSelect = 1'b0;
        fetch.stepOne = 1'b0;
        fetch.stepTwo = 1'b0;
        fetch.loadTarget = 1'b0;
        fetch.targetAddr = RomData;
        exec.loadA = 1'b0;
        exec.loadB = 1'b0;
        exec.takeAlu = 1'b0;
        bus.startRead = 1'b0;
        bus.startWrite = 1'b0;
        bus.writeFromB = selectB;
        bus.accessAddr = RomData;

        case (state)
            // Opcode byte valid, point the ROM at the operand
            seqChoose: begin
                fetch.operandSelect = 1'b1;
                nextSelectB = romWord.mathView.cls inside {opLoadB, opStoreB, opMathB};
                case (romWord.mathView.cls)
                    opLoadA, opLoadB: nextState = seqLoadWait;
                    opStoreA, opStoreB: nextState = seqStoreStep;
                    opMathA, opMathB: nextState = seqMath;
                    opBranch: nextState = seqBranch;
                    opGoto: nextState = seqGotoWait;
                    // Idle and unknown classes both park the processor
                    default: nextState = seqIdle;
                endcase
            end

            // Load chain
            seqLoadWait: nextState = seqLoadIssue;
            seqLoadIssue: begin
                // Operand byte is the data address
                bus.startRead = 1'b1;
                nextState = seqLoadStep;
            end
            seqLoadStep: begin
                fetch.stepTwo = 1'b1;
                nextState = seqLoadTake;
            end
            seqLoadTake: begin
                // Memory data arrived, next opcode is on its way
                exec.loadA = !selectB;
                exec.loadB = selectB;
                nextState = seqChoose;
            end

            // Store chain
            seqStoreStep: begin
                fetch.stepTwo = 1'b1;
                nextState = seqStoreIssue;
            end
            seqStoreIssue: begin
                bus.startWrite = 1'b1;
                nextState = seqChoose;
            end

            // ALU result written in one go
            seqMath: begin
                exec.takeAlu = 1'b1;
                exec.loadA = !selectB;
                exec.loadB = selectB;
                fetch.stepOne = 1'b1;
                nextState = seqMathSettle;
            end
            seqMathSettle: nextState = seqChoose;

            // Branch and goto
            seqBranch: begin
                if (exec.condTrue) begin
                    nextState = seqJumpLoad;
                end else begin
                    // Skip the target byte
                    fetch.stepTwo = 1'b1;
                    nextState = seqJumpSettle;
                end
            end
            seqGotoWait: nextState = seqJumpLoad;
            seqJumpLoad: begin
                fetch.loadTarget = 1'b1;
                nextState = seqJumpSettle;
            end
            // New address is presented, wait for its byte
            seqJumpSettle: nextState = seqChoose;

            // Thread start
            seqIdle: begin
                if (wake) begin
                    fetch.loadTarget = 1'b1;
                    fetch.targetAddr = vectorAddr;
                    nextState = seqVectorWait;
                end
            end
            seqVectorWait: nextState = seqVectorLoad;
            seqVectorLoad: begin
                // Vector byte holds the thread start address
                fetch.loadTarget = 1'b1;
                nextState = seqJumpSettle;
            end

            default: nextState = seqChoose;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit import cpuPkg::*; (
    input  logic                 CLK,
    input  logic                 RESET,
    execLink.receiver            exec,
    output logic [dataWidth-1:0] regA,
    output logic [dataWidth-1:0] regB
);

    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] writeData;

    ////////////////////////////////////////////////////////////////////////////
    // ALU, operation from the maths view of the opcode

    always_comb begin
        case (exec.instr.mathView.op)
            aluAdd: aluResult = regA + regB;
            aluSub: aluResult = regA - regB;
            aluAnd: aluResult = regA & regB;
            aluOr: aluResult = regA | regB;
            aluXor: aluResult = regA ^ regB;
            // Shifts and increment only use A
            aluShiftLeftA: aluResult = regA << 1;
            aluShiftRightA: aluResult = regA >> 1;
            aluIncrementA: aluResult = regA + dataWidth'(1);
            default: aluResult = regA;
        endcase
    end

    // Branch compare, unsigned
    always_comb begin
        case (exec.instr.branchView.cond)
            condEqual: exec.condTrue = (regA == regB);
            condLessThan: exec.condTrue = (regA < regB);
            condGreaterThan: exec.condTrue = (regA > regB);
            condNotEqual: exec.condTrue = (regA != regB);
            default: exec.condTrue = 1'b0;
        endcase
    end

    // Loads take memory data, maths takes the ALU
    assign writeData = exec.takeAlu ? aluResult : exec.memData;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= resetReg;
            regB <= resetReg;
        end else begin
            if (exec.loadA) begin
                regA <= writeData;
            end
            if (exec.loadB) begin
                regB <= writeData;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/busUnit.sv
`timescale 1ns/1ps
`default_nettype none

module busUnit import cpuPkg::*; (
    input  logic                 CLK,
    input  logic                 RESET,
    busLink.receiver             bus,
    input  logic [dataWidth-1:0] regA,
    input  logic [dataWidth-1:0] regB,
    output logic [dataWidth-1:0] BusAddr,
    output logic [dataWidth-1:0] BusDataOut,
    output logic                 BusWe
);

    // Address held for one cycle, then back to the park value
    always_ff @(posedge CLK) begin
        if (RESET) begin
            BusAddr <= idleBusAddr;
            BusWe <= 1'b0;
        end else begin
            BusWe <= bus.startWrite;
            if (bus.startRead || bus.startWrite) begin
                BusAddr <= bus.accessAddr;
            end else begin
                BusAddr <= idleBusAddr;
            end
        end
    end

    // Write data lines up with the strobe
    always_ff @(posedge CLK) begin
        if (bus.startWrite) begin
            BusDataOut <= bus.writeFromB ? regB : regA;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic [dataWidth-1:0] RomData,
    input  logic [dataWidth-1:0] BusDataIn,
    input  logic [irqCount-1:0]  IrqRaise,
    output logic [dataWidth-1:0] RomAddr,
    output logic [dataWidth-1:0] BusAddr,
    output logic [dataWidth-1:0] BusDataOut,
    output logic                 BusWe,
    output logic [irqCount-1:0]  IrqAck
);

    logic                 inIdle;
    logic                 wake;
    logic [dataWidth-1:0] vectorAddr;
    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;

    ////////////////////////////////////////////////////////////////////////////
    // Links around the sequencer

    fetchLink i_fetchLink ();
    execLink  i_execLink ();
    busLink   i_busLink ();

    interruptArbiter i_interruptArbiter (
        .CLK(CLK),
        .RESET(RESET),
        .IrqRaise(IrqRaise),
        .inIdle(inIdle),
        .IrqAck(IrqAck),
        .wake(wake),
        .vectorAddr(vectorAddr)
    );

    fetchUnit i_fetchUnit (
        .CLK(CLK),
        .RESET(RESET),
        .fetch(i_fetchLink.receiver),
        .RomAddr(RomAddr)
    );

    sequencer i_sequencer (
        .CLK(CLK),
        .RESET(RESET),
        .RomData(RomData),
        .BusDataIn(BusDataIn),
        .wake(wake),
        .vectorAddr(vectorAddr),
        .fetch(i_fetchLink.driver),
        .exec(i_execLink.driver),
        .bus(i_busLink.driver),
        .inIdle(inIdle)
    );

    executeUnit i_executeUnit (
        .CLK(CLK),
        .RESET(RESET),
        .exec(i_execLink.receiver),
        .regA(regA),
        .regB(regB)
    );

    // Store data comes straight from the registers
    busUnit i_busUnit (
        .CLK(CLK),
        .RESET(RESET),
        .bus(i_busLink.receiver),
        .regA(regA),
        .regB(regB),
        .BusAddr(BusAddr),
        .BusDataOut(BusDataOut),
        .BusWe(BusWe)
    );

endmodule

`default_nettype wire

//--- bench/programImage.svh
// Program ROM and its write pointer
logic [7:0] rom [256];
logic [7:0] romPtr;
// Model state
logic [7:0] modelMem [256];
logic [7:0] modelA;
logic [7:0] modelB;

// Predicted stores in program order
logic [7:0] expAddr [$];
logic [7:0] expData [$];

task automatic emitByte(input logic [7:0] value);
    rom[romPtr] = value;
    romPtr = romPtr + 8'd1;
endtask

// Opcode followed by its operand byte
task automatic emit(input logic [7:0] op, input logic [7:0] arg);
    emitByte(op);
    emitByte(arg);
endtask

// Loads A and B and branches over the fall-through marker
task automatic branchBlock(input logic [3:0] cond, input logic [7:0] addrA,
                           input logic [7:0] addrB, input logic [7:0] idx);
    emit(8'h00, addrA);
    emit(8'h01, addrB);
    // Target skips the branch and one store
    emit({cond, 4'h6}, romPtr + 8'd4);
    emit(8'h02, 8'hA0 + idx);
    emit(8'h03, 8'hB0 + idx);
endtask

task automatic buildProgram();
    int i;
    for (i = 0; i < 256; i++) begin
        rom[8'(i)] = 8'h08;
    end
    romPtr = 8'h00;
    // Plain loads and stores
    emit(8'h00, 8'h05);
    emit(8'h01, 8'h06);
    emit(8'h02, 8'h80);
    emit(8'h03, 8'h81);
    // Every ALU op into A with each result stored
    for (i = 0; i < 8; i++) begin
        emitByte({i[3:0], 4'h4});
        emit(8'h02, 8'h82 + 8'(i));
    end
    // Fresh A and then every ALU op into B
    emit(8'h00, 8'h07);
    for (i = 0; i < 8; i++) begin
        emitByte({i[3:0], 4'h5});
        emit(8'h03, 8'h8A + 8'(i));
    end
    // Taken and untaken for all four conditions
    branchBlock(4'd0, 8'h10, 8'h10, 8'd0);
    branchBlock(4'd0, 8'h10, 8'h11, 8'd1);
    branchBlock(4'd1, 8'h12, 8'h13, 8'd2);
    branchBlock(4'd1, 8'h13, 8'h12, 8'd3);
    branchBlock(4'd2, 8'h14, 8'h15, 8'd4);
    branchBlock(4'd2, 8'h15, 8'h14, 8'd5);
    branchBlock(4'd3, 8'h16, 8'h17, 8'd6);
    branchBlock(4'd3, 8'h16, 8'h16, 8'd7);
    // Goto jumps over the first marker
    emit(8'h07, romPtr + 8'd4);
    emit(8'h02, 8'hC8);
    emit(8'h03, 8'hC9);
    emitByte(8'h08);
    // Threads at E0, E8 and F0 with vectors counting down from FF
    for (i = 0; i < 3; i++) begin
        romPtr = 8'hE0 + 8'(8 * i);
        rom[8'hFF - 8'(i)] = romPtr;
        emit(8'h00, 8'h20 + 8'(i));
        emit(8'h02, 8'hC0 + 8'(i));
        emitByte(8'h08);
    end
endtask

function automatic logic [7:0] aluModel(input logic [3:0] op, input logic [7:0] a,
                                        input logic [7:0] b);
    case (op)
        4'd0: return a + b;
        4'd1: return a - b;
        4'd2: return a & b;
        4'd3: return a | b;
        4'd4: return a ^ b;
        4'd5: return {a[6:0], 1'b0};
        4'd6: return {1'b0, a[7:1]};
        4'd7: return a + 8'd1;
        default: return a;
    endcase
endfunction

// Unsigned compare of A against B
function automatic bit condModel(input logic [3:0] cond, input logic [7:0] a,
                                 input logic [7:0] b);
    case (cond)
        4'd0: return a == b;
        4'd1: return a < b;
        4'd2: return a > b;
        4'd3: return a != b;
        default: return 1'b0;
    endcase
endfunction

// Runs from startPc up to the next idle and queues each store
task automatic modelRun(input logic [7:0] startPc);
    logic [7:0] pc;
    logic [7:0] op;
    logic [7:0] arg;
    int steps;
    pc = startPc;
    steps = 0;
    while (steps < 300) begin
        op = rom[pc];
        arg = rom[pc + 8'd1];
        steps++;
        case (op[3:0])
            4'h0: modelA = modelMem[arg];
            4'h1: modelB = modelMem[arg];
            4'h2: begin
                expAddr.push_back(arg);
                expData.push_back(modelA);
                modelMem[arg] = modelA;
            end
            4'h3: begin
                expAddr.push_back(arg);
                expData.push_back(modelB);
                modelMem[arg] = modelB;
            end
            4'h4: modelA = aluModel(op[7:4], modelA, modelB);
            4'h5: modelB = aluModel(op[7:4], modelA, modelB);
            default: ;
        endcase
        // Next address where idle and unknown classes end the run
        case (op[3:0])
            4'h4, 4'h5: pc = pc + 8'd1;
            4'h6: pc = condModel(op[7:4], modelA, modelB) ? arg : pc + 8'd2;
            4'h7: pc = arg;
            4'h0, 4'h1, 4'h2, 4'h3: pc = pc + 8'd2;
            default: steps = 300;
        endcase
    end
endtask

//--- bench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    // Longest run is a few hundred cycles of main program and threads
    localparam int cycleLimit = 3000;
    localparam int rounds = 6;

    logic       CLK = 1'b0;
    logic       RESET = 1'b1;
    logic [7:0] RomData = '0;
    logic [7:0] BusDataIn = '0;
    logic [2:0] IrqRaise = '0;
    logic [7:0] RomAddr;
    logic [7:0] BusAddr;
    logic [7:0] BusDataOut;
    logic       BusWe;
    logic [2:0] IrqAck;

    logic [7:0] dataMem [256];
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         afterReset = 0;
    logic       prevWe = 1'b0;
    logic [2:0] prevAck = '0;
    int         round;
    int         i;
    logic [2:0] pending;

    `include "programImage.svh"

    cpuTop i_cpuTop (
        .CLK(CLK),
        .RESET(RESET),
        .RomData(RomData),
        .BusDataIn(BusDataIn),
        .IrqRaise(IrqRaise),
        .RomAddr(RomAddr),
        .BusAddr(BusAddr),
        .BusDataOut(BusDataOut),
        .BusWe(BusWe),
        .IrqAck(IrqAck)
    );

    initial begin
        forever #2 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Check helpers

    task automatic expectValue(input string what, input logic [7:0] got,
                               input logic [7:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic expectTrue(input string what, input bit ok);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    // Index of the lowest raised line or -1 for none
    function automatic int lowestRaised(input logic [2:0] lines);
        int found;
        found = -1;
        for (int k = 0; k < 3; k++) begin
            if (lines[k] && found < 0) begin
                found = k;
            end
        end
        return found;
    endfunction

    task automatic checkStore();
        if (expAddr.size() == 0) begin
            expectTrue("store seen when none was expected", 1'b0);
        end else begin
            expectValue("store address", BusAddr, expAddr.pop_front());
            expectValue("store data", BusDataOut, expData.pop_front());
        end
    endtask

    task automatic checkAck();
        int line;
        line = lowestRaised(IrqRaise);
        expectTrue("IrqAck is not one-hot", $onehot(IrqAck));
        expectTrue("IrqAck lasted more than one cycle", prevAck == '0);
        // Pending stores mean the running code has not reached idle yet
        expectTrue("IrqAck while the processor was not idle", expAddr.size() == 0);
        if (line < 0) begin
            expectTrue("IrqAck with no line raised", 1'b0);
        end else begin
            expectValue("IrqAck", {5'b0, IrqAck}, 8'(1 << line));
            // Woken thread starts at the address held in its vector byte
            modelRun(rom[8'hFF - 8'(line)]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Registered ROM and data memory models

    always @(posedge CLK) begin
        RomData <= rom[RomAddr];
        BusDataIn <= dataMem[BusAddr];
        if (BusWe) begin
            dataMem[BusAddr] <= BusDataOut;
        end
    end

    // Output monitor sampling the values of the cycle just ended
    always @(posedge CLK) begin
        if (RESET) begin
            afterReset = 0;
        end else begin
            // No access can start before the third cycle
            if (afterReset < 3) begin
                expectValue("BusAddr after reset", BusAddr, 8'hFF);
                expectTrue("BusWe high right after reset", BusWe == 1'b0);
                expectTrue("IrqAck high right after reset", IrqAck == '0);
            end
            afterReset = afterReset + 1;
            expectTrue("BusWe high for two cycles", !(BusWe && prevWe));
            if (BusWe) begin
                checkStore();
            end
            if (IrqAck != '0) begin
                checkAck();
            end
            prevWe = BusWe;
            prevAck = IrqAck;
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        void'($urandom(32'h4e669523));
        for (i = 0; i < 256; i++) begin
            dataMem[8'(i)] = 8'($urandom);
            modelMem[8'(i)] = dataMem[8'(i)];
        end
        buildProgram();
        modelA = 8'h00;
        modelB = 8'h00;
        modelRun(8'h00);
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        // First set arrives while the main program still runs
        for (round = 0; round < rounds; round++) begin
            @(posedge CLK);
            IrqRaise <= 3'(1 + $urandom % 7);
            pending = '1;
            // Drop each line once its ack has been seen
            while (pending != '0) begin
                @(posedge CLK);
                pending = IrqRaise & ~IrqAck;
                IrqRaise <= pending;
            end
        end
        repeat (2) @(posedge CLK);
        while (expAddr.size() != 0) begin
            @(posedge CLK);
        end
        // Quiet tail catches stray stores or acks
        repeat (20) @(posedge CLK);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+bench
rtl/cpuPkg.sv
rtl/cpuLinks.sv
rtl/interruptArbiter.sv
rtl/fetchUnit.sv
rtl/sequencer.sv
rtl/executeUnit.sv
rtl/busUnit.sv
rtl/cpuTop.sv
bench/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpuSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
